// ==== Makefile ====
TOP_TB = strand_select_stage_tb
OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f strand_select_stage.f \
		--top-module $(TOP_TB) --Mdir $(OBJ_DIR) -o V$(TOP_TB)

run: build
	./$(OBJ_DIR)/V$(TOP_TB)

lint:
	verilator --lint-only --timing -f strand_select_stage.f --top-module $(TOP_TB)
	verilator --lint-only +incdir+hdl hdl/issue_pkg.sv hdl/strand_fsm.sv \
		hdl/rr_arbiter.sv hdl/strand_select_stage.sv --top-module strand_select_stage

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/issue_defs.svh ====
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// Strands sharing one core, issued barrel style
`define STRANDS_PER_CORE 4

// Bits needed to name one strand
`define STRAND_INDEX_WIDTH 2

// Lanes in a vector register, stepped 15 down to 0 for strided access
`define VECTOR_LANES 16

// Issued when no strand can go
`define NOP_WORD 32'h0000_0000

// Cycles a strand sits out after a long-latency issue
`define RAW_WAIT_CYCLES 3

`endif

// ==== hdl/issue_pkg.sv ====
`include "issue_defs.svh"

package issue_pkg;

	// Memory format of an instruction word
	typedef struct packed
	{
		logic is_memory;	// Bit 31, memory access
		logic is_strided;	// Bit 30, strided vector access
		logic [9:0] stride;	// Byte step between lanes
		logic [4:0] src_reg;
		logic [4:0] base_reg;	// Holds base address
		logic [4:0] dest_reg;
		logic [4:0] mem_op;	// Access size and kind
	} memory_view_t;

	// Same 32 bits, either as a plain word or decoded as a memory op
	typedef union packed
	{
		logic [31:0] raw;
		memory_view_t mem;
	} instruction_t;

	// Per-strand scheduling state
	typedef enum logic [1:0]
	{
		ready,		// Scalar or first lane may issue
		vector_loop,	// Mid strided vector, more lanes to go
		raw_wait,	// Holding off after long-latency issue
		dcache_wait	// Parked on a data cache miss
	} strand_state_t;

endpackage

// ==== hdl/rr_arbiter.sv ====
`include "issue_defs.svh"

module rr_arbiter
#(
	parameter int NUM_ENTRIES = `STRANDS_PER_CORE
)
(
	input logic clk,
	input logic reset,
	input logic [NUM_ENTRIES-1:0] request,
	output logic [NUM_ENTRIES-1:0] grant_oh
);

	localparam int INDEX_WIDTH = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

	logic [INDEX_WIDTH-1:0] priority_ptr;	// Entry with top priority
	logic [INDEX_WIDTH-1:0] winner;
	logic winner_valid;

	// Index step with wraparound, works for any entry count
	function automatic logic [INDEX_WIDTH-1:0] wrap_add(input logic [INDEX_WIDTH-1:0] base,
		input int step);
		int sum;
		sum = int'(base) + step;
		if (sum >= NUM_ENTRIES)
			sum = sum - NUM_ENTRIES;
		return INDEX_WIDTH'(sum);
	endfunction

	// Scan from the pointer, first requester wins
	always_comb
	begin
		winner = priority_ptr;
		winner_valid = 1'b0;
		for (int k = 0; k < NUM_ENTRIES; k++)
		begin
			if (!winner_valid && request[wrap_add(priority_ptr, k)])
			begin
				winner = wrap_add(priority_ptr, k);
				winner_valid = 1'b1;
			end
		end

		grant_oh = '0;
		if (winner_valid)
			grant_oh[winner] = 1'b1;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			priority_ptr <= '0;	// Entry 0 first out of reset
		else if (winner_valid)
			priority_ptr <= wrap_add(winner, 1);	// Winner drops to last
	end

endmodule

// ==== hdl/strand_fsm.sv ====
`include "issue_defs.svh"

module strand_fsm
(
	input logic clk,
	input logic reset,

	// Fetch side, this strand only
	input logic if_instruction_valid,
	input issue_pkg::instruction_t if_instruction,
	input logic if_long_latency,
	output logic ss_instruction_req,

	// Grant bit for this strand from the arbiter
	input logic issue_strand_oh,

	// Rollback controller
	input logic rb_rollback_strand,
	input logic suspend_strand,
	input logic resume_strand,
	input logic [31:0] rollback_strided_offset,
	input logic [$clog2(`VECTOR_LANES)-1:0] rollback_reg_lane,

	// To the select logic
	output logic strand_ready,
	output logic [$clog2(`VECTOR_LANES)-1:0] reg_lane_select,
	output logic [31:0] strided_offset,

	// Performance events
	output logic pc_event_raw_wait,
	output logic pc_event_dcache_wait,
	output logic pc_event_icache_wait
);

	localparam int LANE_WIDTH = $clog2(`VECTOR_LANES);
	localparam int WAIT_WIDTH = $clog2(`RAW_WAIT_CYCLES + 1);
	localparam logic [LANE_WIDTH-1:0] FIRST_LANE = LANE_WIDTH'(`VECTOR_LANES - 1);
	localparam logic [WAIT_WIDTH-1:0] WAIT_LOAD = WAIT_WIDTH'(`RAW_WAIT_CYCLES - 1);

	issue_pkg::strand_state_t state;
	issue_pkg::strand_state_t state_next;
	logic [LANE_WIDTH-1:0] lane;
	logic [LANE_WIDTH-1:0] lane_next;
	logic [31:0] offset;
	logic [31:0] offset_next;
	logic [WAIT_WIDTH-1:0] wait_count;
	logic [WAIT_WIDTH-1:0] wait_count_next;
	logic is_strided;	// Current word is a strided vector memory op
	logic last_issue;	// Grant now finishes the instruction

	assign is_strided = if_instruction.mem.is_memory && if_instruction.mem.is_strided;

	// Scalars finish in one go, vectors on lane 0
	assign last_issue = !is_strided || (lane == '0);

	// Ask fetch for the next word only once the whole instruction is out
	assign ss_instruction_req = issue_strand_oh && last_issue;

	assign strand_ready = ((state == issue_pkg::ready) || (state == issue_pkg::vector_loop))
		&& if_instruction_valid;

	assign reg_lane_select = lane;
	assign strided_offset = offset;

	assign pc_event_raw_wait = (state == issue_pkg::raw_wait);
	assign pc_event_dcache_wait = (state == issue_pkg::dcache_wait);
	assign pc_event_icache_wait = (state == issue_pkg::ready) && !if_instruction_valid;

	always_comb
	begin
		state_next = state;
		lane_next = lane;
		offset_next = offset;
		wait_count_next = wait_count;

		case (state)
			issue_pkg::ready,
			issue_pkg::vector_loop:
			begin
				if (issue_strand_oh)
				begin
					if (last_issue)
					begin
						// Rearm lane stepping for the next instruction
						lane_next = FIRST_LANE;
						offset_next = '0;
						if (if_long_latency)
						begin
							state_next = issue_pkg::raw_wait;
							wait_count_next = WAIT_LOAD;
						end
						else
							state_next = issue_pkg::ready;
					end
					else
					begin
						state_next = issue_pkg::vector_loop;
						lane_next = lane - 1'b1;	// Lanes count down
						offset_next = offset + 32'(if_instruction.mem.stride);
					end
				end
			end

			issue_pkg::raw_wait:
			begin
				if (wait_count == '0)
					state_next = issue_pkg::ready;
				else
					wait_count_next = wait_count - 1'b1;
			end

			issue_pkg::dcache_wait:
			begin
				// Lane and offset kept, ready picks up mid-vector if needed
				if (resume_strand)
					state_next = issue_pkg::ready;
			end

			default:
				state_next = issue_pkg::ready;
		endcase

		// Cache miss parks the strand regardless of what it was doing
		if (suspend_strand)
			state_next = issue_pkg::dcache_wait;

		// Rollback beats everything else
		if (rb_rollback_strand)
		begin
			lane_next = rollback_reg_lane;
			offset_next = rollback_strided_offset;
			if (suspend_strand)
				state_next = issue_pkg::dcache_wait;	// Retry after the miss
			else if (rollback_reg_lane != '0)
				state_next = issue_pkg::vector_loop;
			else
				state_next = issue_pkg::ready;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= issue_pkg::ready;
			lane <= FIRST_LANE;
			offset <= '0;
			wait_count <= '0;
		end
		else
		begin
			state <= state_next;
			lane <= lane_next;
			offset <= offset_next;
			wait_count <= wait_count_next;
		end
	end

endmodule

// ==== hdl/strand_select_stage.sv ====
`include "issue_defs.svh"

module strand_select_stage
(
	input logic clk,
	input logic reset,

	// Control register unit
	input logic [`STRANDS_PER_CORE-1:0] cr_strand_enable,

	// Fetch stage, strands packed side by side
	input logic [`STRANDS_PER_CORE-1:0] if_instruction_valid,
	input logic [`STRANDS_PER_CORE*32-1:0] if_instruction,
	input logic [`STRANDS_PER_CORE*32-1:0] if_pc,
	input logic [`STRANDS_PER_CORE-1:0] if_branch_predicted,
	input logic [`STRANDS_PER_CORE-1:0] if_long_latency,
	output logic [`STRANDS_PER_CORE-1:0] ss_instruction_req,

	// Rollback controller
	input logic [`STRANDS_PER_CORE-1:0] rb_rollback_strand,
	input logic [`STRANDS_PER_CORE-1:0] suspend_strand,
	input logic [`STRANDS_PER_CORE-1:0] resume_strand,
	input logic [`STRANDS_PER_CORE*32-1:0] rollback_strided_offset,
	input logic [`STRANDS_PER_CORE*$clog2(`VECTOR_LANES)-1:0] rollback_reg_lane,

	// Decode stage
	output logic [31:0] ss_pc,
	output logic [31:0] ss_instruction,
	output logic [$clog2(`VECTOR_LANES)-1:0] ss_reg_lane_select,
	output logic [31:0] ss_strided_offset,
	output logic [`STRAND_INDEX_WIDTH-1:0] ss_strand,
	output logic ss_branch_predicted,
	output logic ss_long_latency,

	// Performance events
	output logic [`STRANDS_PER_CORE-1:0] pc_event_raw_wait,
	output logic [`STRANDS_PER_CORE-1:0] pc_event_dcache_wait,
	output logic [`STRANDS_PER_CORE-1:0] pc_event_icache_wait,
	output logic pc_event_instruction_issue
);

	localparam int LANE_WIDTH = $clog2(`VECTOR_LANES);

	logic [`STRANDS_PER_CORE*LANE_WIDTH-1:0] reg_lane_select;
	logic [`STRANDS_PER_CORE*32-1:0] strided_offset;
	logic [`STRANDS_PER_CORE-1:0] strand_ready;
	logic [`STRANDS_PER_CORE-1:0] issue_request;
	logic [`STRANDS_PER_CORE-1:0] issue_strand_oh;
	logic [`STRANDS_PER_CORE-1:0] short_latency;	// Short op, not a NOP
	logic [`STRANDS_PER_CORE-1:0] execute_hazard;
	logic [`STRAND_INDEX_WIDTH-1:0] issue_strand_idx;
	logic issue_long_latency;
	issue_pkg::instruction_t strand_instruction [`STRANDS_PER_CORE];

	// Short and long pipes merge at writeback. Each bit follows one
	// issued instruction, bit 2 oldest. A set oldest bit means a short op
	// issued now would land at writeback in the same cycle
	logic [2:0] writeback_shadow;

	assign issue_long_latency = |(issue_strand_oh & if_long_latency);
	assign execute_hazard = {`STRANDS_PER_CORE{writeback_shadow[2]}} & short_latency;

	// Candidates: ready, enabled and clear of the writeback clash
	assign issue_request = strand_ready & cr_strand_enable & ~execute_hazard;

	for (genvar i = 0; i < `STRANDS_PER_CORE; i++)
	begin : g_strand
		assign strand_instruction[i] = if_instruction[i*32 +: 32];

		// NOPs never reach writeback, no clash possible
		assign short_latency[i] = !if_long_latency[i]
			&& (strand_instruction[i].raw != `NOP_WORD);

		strand_fsm u_strand_fsm
		(
			.clk(clk),
			.reset(reset),
			.if_instruction_valid(if_instruction_valid[i]),
			.if_instruction(strand_instruction[i]),
			.if_long_latency(if_long_latency[i]),
			.ss_instruction_req(ss_instruction_req[i]),
			.issue_strand_oh(issue_strand_oh[i]),
			.rb_rollback_strand(rb_rollback_strand[i]),
			.suspend_strand(suspend_strand[i]),
			.resume_strand(resume_strand[i]),
			.rollback_strided_offset(rollback_strided_offset[i*32 +: 32]),
			.rollback_reg_lane(rollback_reg_lane[i*LANE_WIDTH +: LANE_WIDTH]),
			.strand_ready(strand_ready[i]),
			.reg_lane_select(reg_lane_select[i*LANE_WIDTH +: LANE_WIDTH]),
			.strided_offset(strided_offset[i*32 +: 32]),
			.pc_event_raw_wait(pc_event_raw_wait[i]),
			.pc_event_dcache_wait(pc_event_dcache_wait[i]),
			.pc_event_icache_wait(pc_event_icache_wait[i])
		);
	end

	rr_arbiter
	#(
		.NUM_ENTRIES(`STRANDS_PER_CORE)
	)
	u_issue_arbiter
	(
		.clk(clk),
		.reset(reset),
		.request(issue_request),
		.grant_oh(issue_strand_oh)
	);

	// One-hot grant to strand number, OR of the set positions
	always_comb
	begin
		issue_strand_idx = '0;
		for (int i = 0; i < `STRANDS_PER_CORE; i++)
			if (issue_strand_oh[i])
				issue_strand_idx = issue_strand_idx | `STRAND_INDEX_WIDTH'(i);
	end

	assign pc_event_instruction_issue = |issue_strand_oh;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			writeback_shadow <= '0;
			ss_pc <= '0;
			ss_instruction <= `NOP_WORD;
			ss_reg_lane_select <= '0;
			ss_strided_offset <= '0;
			ss_strand <= '0;
			ss_branch_predicted <= 1'b0;
			ss_long_latency <= 1'b0;
		end
		else
		begin
			writeback_shadow <= {writeback_shadow[1:0], issue_long_latency};

			if (pc_event_instruction_issue)
			begin
				// Winner's fields to decode
				ss_pc <= if_pc[issue_strand_idx*32 +: 32];
				ss_instruction <= strand_instruction[issue_strand_idx].raw;
				ss_branch_predicted <= if_branch_predicted[issue_strand_idx];
				ss_long_latency <= if_long_latency[issue_strand_idx];
				ss_reg_lane_select <= reg_lane_select[issue_strand_idx*LANE_WIDTH +: LANE_WIDTH];
				ss_strided_offset <= strided_offset[issue_strand_idx*32 +: 32];
				ss_strand <= issue_strand_idx;
			end
			else
			begin
				// Bubble, strand/lane/offset keep last values
				ss_pc <= '0;
				ss_instruction <= `NOP_WORD;
				ss_branch_predicted <= 1'b0;
				ss_long_latency <= 1'b0;
			end
		end
	end

endmodule

// ==== strand_select_stage.f ====
+incdir+hdl
hdl/issue_pkg.sv
hdl/strand_fsm.sv
hdl/rr_arbiter.sv
hdl/strand_select_stage.sv
verification/strand_select_stage_tb.sv

// ==== verification/issue_patterns.txt ====
# c mask en valid ll bp rb susp res rblane rboff i0 i1 i2 i3 pcbase (pc of strand n = pcbase + n*100)
# expected: pc instr lane offset strand bp ll req raw dcache icache issue
c 1f f f 0 0 0 0 0 0 00000000 00001110 00002220 00003330 00004440 00001000 00000000 00000000 0 00000000 0 0 0 1 0 0 0 1
c 1f f f 0 0 0 0 0 0 00000000 00001110 00002220 00003330 00004440 00001000 00001000 00001110 f 00000000 0 0 0 2 0 0 0 1
c 1f f f 0 0 0 0 0 0 00000000 00001110 00002220 00003330 00004440 00001000 00001100 00002220 f 00000000 1 0 0 4 0 0 0 1
c 1f f f 0 8 0 0 0 0 00000000 00001110 00002220 00003330 00004440 00001000 00001200 00003330 f 00000000 2 0 0 8 0 0 0 1
c 1f f f 0 0 0 0 0 0 00000000 00001110 00002220 00003330 00004440 00001000 00001300 00004440 f 00000000 3 1 0 1 0 0 0 1
c 1f f 0 0 0 0 0 0 0 00000000 00001110 00002220 00003330 00004440 00001000 00001000 00001110 f 00000000 0 0 0 0 0 0 f 0
c 1f f 0 0 0 0 0 0 0 00000000 00001110 00002220 00003330 00004440 00001000 00000000 00000000 f 00000000 0 0 0 0 0 0 f 0
c 1f 5 f 0 0 0 0 0 0 00000000 00001110 00002220 00003330 00004440 00001000 00000000 00000000 f 00000000 0 0 0 4 0 0 0 1
c 1f 5 f 0 0 0 0 0 0 00000000 00001110 00002220 00003330 00004440 00001000 00001200 00003330 f 00000000 2 0 0 1 0 0 0 1
c 1f 5 a 0 0 0 0 0 0 00000000 00001110 00002220 00003330 00004440 00001000 00001000 00001110 f 00000000 0 0 0 0 0 0 5 0
# strided vector on strand 1, stride 8
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00000000 00000000 f 00000000 0 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 f 00000000 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 e 00000008 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 d 00000010 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 c 00000018 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 b 00000020 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 a 00000028 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 9 00000030 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 8 00000038 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 7 00000040 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 6 00000048 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 5 00000050 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 4 00000058 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 3 00000060 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 2 00000068 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 1 00000070 1 0 0 2 0 0 d 1
# long-latency issue on strand 2, then RAW wait and writeback clash
c 1f f 4 4 0 0 0 0 0 00000000 00001110 c0800123 00005550 00004440 00001000 00001100 c0800123 0 00000078 1 0 0 4 0 0 b 1
c 1f f 0 0 0 0 0 0 0 00000000 00001110 c0800123 00005550 00004440 00001000 00001200 00005550 f 00000000 2 0 1 0 4 0 b 0
c 1f f 0 0 0 0 0 0 0 00000000 00001110 c0800123 00005550 00004440 00001000 00000000 00000000 f 00000000 2 0 0 0 4 0 b 0
c 1f f 9 0 0 0 0 0 0 00000000 00001110 c0800123 00005550 00000000 00001000 00000000 00000000 f 00000000 2 0 0 8 4 0 2 1
c 1f f 1 0 0 0 0 0 0 00000000 00001110 c0800123 00005550 00000000 00001000 00001300 00000000 f 00000000 3 0 0 1 0 0 e 1
# suspend, resume and rollback on strand 1
c 1f f 0 0 0 0 2 0 0 00000000 00001110 00002220 00003330 00004440 00001000 00001000 00001110 f 00000000 0 0 0 0 0 0 f 0
c 1f f 3 0 0 0 0 0 0 00000000 00001110 00002220 00003330 00004440 00001000 00000000 00000000 f 00000000 0 0 0 1 0 2 c 1
c 1f f 2 0 0 0 0 2 0 00000000 00001110 00002220 00003330 00004440 00001000 00001000 00001110 f 00000000 0 0 0 0 0 2 d 0
c 1f f 2 0 0 0 0 0 0 00000000 00001110 00002220 00003330 00004440 00001000 00000000 00000000 f 00000000 0 0 0 2 0 0 d 1
c 1f f 0 0 0 2 0 0 5 00000100 00001110 00002220 00003330 00004440 00001000 00001100 00002220 f 00000000 1 0 0 0 0 0 f 0
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00000000 00000000 f 00000000 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 5 00000100 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 4 00000108 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 3 00000110 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 2 00000118 1 0 0 0 0 0 d 1
c 1f f 2 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 1 00000120 1 0 0 2 0 0 d 1
c 1f f 0 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00001100 c0800123 0 00000128 1 0 0 0 0 0 f 0
c 1f f 0 0 0 0 0 0 0 00000000 00001110 c0800123 00003330 00004440 00001000 00000000 00000000 0 00000128 1 0 0 0 0 0 f 0
end

// ==== verification/strand_select_stage_tb.sv ====
module strand_select_stage_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_PATTERNS = 64;	// Upper bound on lines in the pattern file
	localparam int TIMEOUT_NS = (RESET_CYCLES + MAX_PATTERNS) * CLK_PERIOD + 400;

	logic clk;
	logic reset;
	logic [3:0] cr_strand_enable;
	logic [3:0] if_instruction_valid;
	logic [127:0] if_instruction;
	logic [127:0] if_pc;
	logic [3:0] if_branch_predicted;
	logic [3:0] if_long_latency;
	logic [3:0] ss_instruction_req;
	logic [3:0] rb_rollback_strand;
	logic [3:0] suspend_strand;
	logic [3:0] resume_strand;
	logic [127:0] rollback_strided_offset;
	logic [15:0] rollback_reg_lane;
	logic [31:0] ss_pc;
	logic [31:0] ss_instruction;
	logic [3:0] ss_reg_lane_select;
	logic [31:0] ss_strided_offset;
	logic [1:0] ss_strand;
	logic ss_branch_predicted;
	logic ss_long_latency;
	logic [3:0] pc_event_raw_wait;
	logic [3:0] pc_event_dcache_wait;
	logic [3:0] pc_event_icache_wait;
	logic pc_event_instruction_issue;

	strand_select_stage UUT
	(
		.clk(clk),
		.reset(reset),
		.cr_strand_enable(cr_strand_enable),
		.if_instruction_valid(if_instruction_valid),
		.if_instruction(if_instruction),
		.if_pc(if_pc),
		.if_branch_predicted(if_branch_predicted),
		.if_long_latency(if_long_latency),
		.ss_instruction_req(ss_instruction_req),
		.rb_rollback_strand(rb_rollback_strand),
		.suspend_strand(suspend_strand),
		.resume_strand(resume_strand),
		.rollback_strided_offset(rollback_strided_offset),
		.rollback_reg_lane(rollback_reg_lane),
		.ss_pc(ss_pc),
		.ss_instruction(ss_instruction),
		.ss_reg_lane_select(ss_reg_lane_select),
		.ss_strided_offset(ss_strided_offset),
		.ss_strand(ss_strand),
		.ss_branch_predicted(ss_branch_predicted),
		.ss_long_latency(ss_long_latency),
		.pc_event_raw_wait(pc_event_raw_wait),
		.pc_event_dcache_wait(pc_event_dcache_wait),
		.pc_event_icache_wait(pc_event_icache_wait),
		.pc_event_instruction_issue(pc_event_instruction_issue)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	// Stops the run after the first error
	task automatic fail_run();
		$display("Regression failed");
		$fatal(1, "Run stopped on error");
	endtask

	task automatic compare_field(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("Mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
			fail_run();
		end
	endtask

	// Watchdog covering the whole pattern file plus margin
	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the pattern run did not reach its end marker in time");
		fail_run();
	end

	initial
	begin
		int fd;
		int count;
		int line_no;
		logic [8*16-1:0] tag;
		logic [8*256-1:0] skipped;
		logic [31:0] mask, en, valid, ll, bp, rb, susp, res, rb_lane, rb_off;
		logic [31:0] i0, i1, i2, i3, pc_base;
		logic [31:0] e_pc, e_instr, e_lane, e_off, e_strand, e_bp, e_ll;
		logic [31:0] e_req, e_raw, e_dc, e_ic, e_issue;

		// Quiet inputs through reset
		reset = 1'b1;
		cr_strand_enable = '0;
		if_instruction_valid = '0;
		if_instruction = '0;
		if_pc = '0;
		if_branch_predicted = '0;
		if_long_latency = '0;
		rb_rollback_strand = '0;
		suspend_strand = '0;
		resume_strand = '0;
		rollback_strided_offset = '0;
		rollback_reg_lane = '0;
		line_no = 0;

		fd = $fopen("verification/issue_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the pattern file verification/issue_patterns.txt");
			fail_run();
		end

		repeat (RESET_CYCLES) @(posedge clk);
		#4 reset = 1'b0;

		forever
		begin
			count = $fscanf(fd, "%s", tag);
			if (count != 1)
			begin
				$display("Pattern file ended before its end marker");
				fail_run();
			end
			if (tag == "#")
				count = $fgets(skipped, fd);	// Column notes
			else if (tag == "end")
				break;
			else
			begin
				count = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					mask, en, valid, ll, bp, rb, susp, res, rb_lane, rb_off,
					i0, i1, i2, i3, pc_base);
				count += $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
					e_pc, e_instr, e_lane, e_off, e_strand, e_bp, e_ll,
					e_req, e_raw, e_dc, e_ic, e_issue);
				line_no++;
				if (count != 27)
				begin
					$display("Malformed pattern line %0d", line_no);
					fail_run();
				end

				// Drive 4 ns past the edge
				cr_strand_enable = en[3:0];
				if_instruction_valid = valid[3:0];
				if_long_latency = ll[3:0];
				if_branch_predicted = bp[3:0];
				rb_rollback_strand = rb[3:0];
				suspend_strand = susp[3:0];
				resume_strand = res[3:0];
				rollback_reg_lane = {4{rb_lane[3:0]}};	// Same lane offered to all
				rollback_strided_offset = {4{rb_off}};
				if_instruction = {i3, i2, i1, i0};
				if_pc = {pc_base + 32'h300, pc_base + 32'h200, pc_base + 32'h100, pc_base};

				#(CLK_PERIOD - 5);	// Sample 1 ns before next edge

				if (mask[0])
				begin
					compare_field("ss_pc", e_pc, ss_pc);
					compare_field("ss_instruction", e_instr, ss_instruction);
					compare_field("ss_branch_predicted", e_bp, 32'(ss_branch_predicted));
					compare_field("ss_long_latency", e_ll, 32'(ss_long_latency));
				end
				if (mask[1])
				begin
					compare_field("ss_strand", e_strand, 32'(ss_strand));
					compare_field("ss_reg_lane_select", e_lane, 32'(ss_reg_lane_select));
					compare_field("ss_strided_offset", e_off, ss_strided_offset);
				end
				if (mask[2])
					compare_field("ss_instruction_req", e_req, 32'(ss_instruction_req));
				if (mask[3])
				begin
					compare_field("pc_event_raw_wait", e_raw, 32'(pc_event_raw_wait));
					compare_field("pc_event_dcache_wait", e_dc, 32'(pc_event_dcache_wait));
					compare_field("pc_event_icache_wait", e_ic, 32'(pc_event_icache_wait));
				end
				if (mask[4])
					compare_field("pc_event_instruction_issue", e_issue,
						32'(pc_event_instruction_issue));

				@(posedge clk);
				#4;
			end
		end

		$fclose(fd);
		if (line_no > 0)
		begin
			$display("Regression passed");
			$finish;
		end
		else
		begin
			$display("No pattern lines were checked");
			fail_run();
		end
	end

endmodule
